// File: filelist.f
logic/dma_pkg.sv
logic/dma_req_slice.sv
logic/dma_region_splitter.sv
logic/dma_group_distributor.sv
logic/dma_status_tracker.sv
logic/dma_frontend.sv
tb/dma_group_agent.sv
tb/tb_dma_frontend.sv

// File: run_sim.sh
#!/bin/sh
# Build the DMA front end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dma_frontend \
  -f filelist.f -o tb_dma_frontend || exit 1
out=$(./obj_dir/tb_dma_frontend 2>&1)
echo "$out"
echo "$out" | grep -q "^Everything OK$" && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// File: tb/tb_dma_frontend.sv
// ##########################################################
// DMA front end testbench
// Random requests checked against a piece model, plus idle
// ##########################################################

`timescale 1ns/1ps

module tb_dma_frontend import dma_pkg::*; ();

  localparam int unsigned NumIsolated = 20;
  localparam int unsigned NumRandom   = 300;
  localparam int unsigned CycleLimit  = 200 * (NumIsolated + NumRandom) + 1000;
  localparam logic [31:0] TcdmBase    = 32'h1000_0000;

  logic                 clk;
  logic                 rst;
  logic                 req_valid;
  logic                 req_ready;
  logic [AddrWidth-1:0] req_src;
  logic [AddrWidth-1:0] req_dst;
  logic [LenWidth-1:0]  req_len;
  logic [NumGroups-1:0] group_valid;
  logic [NumGroups-1:0] group_ready;
  logic [AddrWidth-1:0] group_src;
  logic [AddrWidth-1:0] group_dst;
  logic [LenWidth-1:0]  group_len;
  logic [NumGroups-1:0] group_done;
  logic                 dma_idle;
  logic                 all_ready;

  int          seed;
  int unsigned cyc;
  int unsigned pass_cnt;
  int unsigned fail_cnt;
  int unsigned test_errs;
  int unsigned outstanding;
  int unsigned delivered;
  int unsigned expected_total;
  logic        idle_pred;
  int unsigned lat_req_edge;
  int unsigned lat_first_edge;
  int unsigned lat_last_edge;
  int unsigned lat_pieces;

  // Expected pieces, oldest first
  logic [31:0] exp_src[$];
  logic [31:0] exp_dst[$];
  logic [15:0] exp_len[$];
  bit          exp_first[$];

  dma_frontend dut0 (
    .clk_i        (clk        ),
    .rst_i        (rst        ),
    .req_valid_i  (req_valid  ),
    .req_ready_o  (req_ready  ),
    .req_src_i    (req_src    ),
    .req_dst_i    (req_dst    ),
    .req_len_i    (req_len    ),
    .group_valid_o(group_valid),
    .group_ready_i(group_ready),
    .group_src_o  (group_src  ),
    .group_dst_o  (group_dst  ),
    .group_len_o  (group_len  ),
    .group_done_i (group_done ),
    .dma_idle_o   (dma_idle   )
  );

  dma_group_agent group_agent0 (
    .clk_i        (clk        ),
    .all_ready_i  (all_ready  ),
    .group_valid_i(group_valid),
    .group_ready_o(group_ready),
    .group_done_o (group_done )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= CycleLimit) begin
      $display("Timeout after %0d cycles, the DMA never drained", cyc);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h (cycle %0d)", name, got, exp, cyc);
      fail_cnt  = fail_cnt + 1;
      test_errs = test_errs + 1;
    end else begin
      pass_cnt = pass_cnt + 1;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s (cycle %0d)", msg, cyc);
    fail_cnt  = fail_cnt + 1;
    test_errs = test_errs + 1;
  endtask

  // Row boundary cut first, then group boundary cut inside each row piece
  task automatic expand_request(input logic [31:0] src, input logic [31:0] dst,
                                input logic [15:0] len, output int unsigned count);
    logic [31:0] s;
    logic [31:0] d;
    int unsigned left;
    int unsigned row_part;
    int unsigned cut;
    bit          first;
    s     = src;
    d     = dst;
    left  = 32'(len);
    count = 0;
    first = 1'b1;
    while (left != 0) begin
      row_part = RowRegionBytes - (d % RowRegionBytes);
      if (row_part > left) row_part = left;
      left = left - row_part;
      while (row_part != 0) begin
        cut = GroupRegionBytes - (d % GroupRegionBytes);
        if (cut > row_part) cut = row_part;
        exp_src.push_back(s);
        exp_dst.push_back(d);
        exp_len.push_back(16'(cut));
        exp_first.push_back(first);
        first    = 1'b0;
        s        = s + cut;
        d        = d + cut;
        row_part = row_part - cut;
        count    = count + 1;
      end
    end
  endtask

  // Handshakes are sampled mid-cycle and take effect at the next edge
  always @(negedge clk) begin : observe
    logic [31:0]          d0;
    logic [NumGroups-1:0] exp_vld;
    int unsigned          n;
    if (!rst) begin
      check_value("dma_idle_o", 32'(dma_idle), 32'(idle_pred));
      idle_pred = (exp_dst.size() == 0) && (outstanding == 0);
      if (req_valid && req_ready) begin
        lat_req_edge = cyc + 1;
        expand_request(req_src, req_dst, req_len, n);
        lat_pieces     = n;
        expected_total = expected_total + n;
      end
      if (|(group_valid & group_ready)) begin
        if (exp_dst.size() == 0) begin
          note_failure("Group piece delivered with no request outstanding");
        end else begin
          d0      = exp_dst[0];
          exp_vld = NumGroups'(1) << d0[7:6];
          check_value("group_valid_o", 32'(group_valid), 32'(exp_vld));
          check_value("group_src_o", group_src, exp_src[0]);
          check_value("group_dst_o", group_dst, d0);
          check_value("group_len_o", 32'(group_len), 32'(exp_len[0]));
          if (exp_first[0]) lat_first_edge = cyc + 1;
          lat_last_edge = cyc + 1;
          void'(exp_src.pop_front());
          void'(exp_dst.pop_front());
          void'(exp_len.pop_front());
          void'(exp_first.pop_front());
        end
        delivered   = delivered + 1;
        outstanding = outstanding + 1;
      end
      outstanding = outstanding - $countones(group_done);
    end
  end

  task automatic send_request(input bit with_gap);
    logic [31:0] rnd;
    logic [15:0] len;
    rnd = $random(seed);
    if (with_gap) begin
      repeat (rnd[1:0] % 3) begin
        @(posedge clk);
        #1;
      end
    end
    len = 16'(rnd % 32'd600) + 16'd1;
    rnd = $random(seed);
    req_dst   = TcdmBase + (rnd % (32'd1025 - 32'(len)));
    req_src   = $random(seed);
    req_len   = len;
    req_valid = 1'b1;
    do @(negedge clk); while (!req_ready);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  // Model empty, no completions owed and the DUT reports idle
  task automatic wait_drained();
    do begin
      @(posedge clk);
      #1;
    end while (exp_dst.size() != 0 || outstanding != 0 || !dma_idle);
  endtask

  task automatic close_test(input string name);
    $display("Test %s finished with %0d errors", name, test_errs);
    test_errs = 0;
  endtask

  initial begin
    seed           = 32'h9675;
    cyc            = 0;
    pass_cnt       = 0;
    fail_cnt       = 0;
    test_errs      = 0;
    outstanding    = 0;
    delivered      = 0;
    expected_total = 0;
    idle_pred      = 1'b1;
    rst            = 1'b1;
    all_ready      = 1'b1;
    req_valid      = 1'b0;
    req_src        = '0;
    req_dst        = '0;
    req_len        = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("dma_idle_o", 32'(dma_idle), 32'd1);
    check_value("req_ready_o", 32'(req_ready), 32'd1);
    check_value("group_valid_o", 32'(group_valid), 32'd0);
    close_test("reset");

    // Isolated requests with every group ready
    for (int i = 0; i < NumIsolated; i++) begin
      send_request(1'b0);
      wait_drained();
      check_value("first piece latency", lat_first_edge - lat_req_edge, 32'd3);
      check_value("piece run length", lat_last_edge - lat_first_edge + 1, lat_pieces);
    end
    close_test("latency");

    all_ready = 1'b0;
    for (int i = 0; i < NumRandom; i++) begin
      send_request(1'b1);
    end
    wait_drained();
    check_value("pieces delivered", delivered, expected_total);
    close_test("backpressure");

    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: tb/dma_group_agent.sv
// ##########################################################
// Group back end model for the DMA front end testbench
// Random ready and delayed completion pulses per group
// ##########################################################

`timescale 1ns/1ps

module dma_group_agent import dma_pkg::*; (
  input  logic                 clk_i,
  input  logic                 all_ready_i,
  input  logic [NumGroups-1:0] group_valid_i,
  output logic [NumGroups-1:0] group_ready_o,
  output logic [NumGroups-1:0] group_done_o
);

  int          seed;
  int unsigned cyc;
  // Completion pulses still owed and the cycle each one falls due
  int unsigned pend_due[$];
  int unsigned pend_grp[$];

  // At most one pulse per group per cycle, the rest wait
  task automatic release_done();
    int unsigned          keep_due[$];
    int unsigned          keep_grp[$];
    logic [NumGroups-1:0] fire;
    fire = '0;
    for (int i = 0; i < pend_due.size(); i++) begin
      if (pend_due[i] <= cyc && !fire[pend_grp[i]]) begin
        fire[pend_grp[i]] = 1'b1;
      end else begin
        keep_due.push_back(pend_due[i]);
        keep_grp.push_back(pend_grp[i]);
      end
    end
    pend_due     = keep_due;
    pend_grp     = keep_grp;
    group_done_o = fire;
  endtask

  initial begin
    logic [31:0]          rnd;
    logic [NumGroups-1:0] taken;
    seed          = 32'h9675;
    cyc           = 0;
    group_ready_o = '0;
    group_done_o  = '0;
    forever begin
      @(posedge clk_i);
      cyc = cyc + 1;
      #1;
      rnd = $random(seed);
      if (all_ready_i) begin
        group_ready_o = '1;
      end else begin
        group_ready_o = rnd[NumGroups-1:0] | rnd[2*NumGroups-1:NumGroups];
      end
      release_done();
      // Transfer seen here happens at the coming edge
      @(negedge clk_i);
      taken = group_valid_i & group_ready_o;
      for (int g = 0; g < NumGroups; g++) begin
        if (taken[g]) begin
          rnd = $random(seed);
          pend_due.push_back(cyc + 32'(rnd[2:0]) + 1);
          pend_grp.push_back(g);
        end
      end
    end
  end

endmodule

// File: logic/dma_frontend.sv
// ##########################################################
// DMA request front end
// Slice, row splitter, group distributor and idle tracking
// ##########################################################

`timescale 1ns/1ps

module dma_frontend import dma_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [AddrWidth-1:0] req_src_i,
  input  logic [AddrWidth-1:0] req_dst_i,
  input  logic [LenWidth-1:0]  req_len_i,
  output logic [NumGroups-1:0] group_valid_o,
  input  logic [NumGroups-1:0] group_ready_i,
  output logic [AddrWidth-1:0] group_src_o,
  output logic [AddrWidth-1:0] group_dst_o,
  output logic [LenWidth-1:0]  group_len_o,
  input  logic [NumGroups-1:0] group_done_i,
  output logic                 dma_idle_o
);

  logic                 slice_valid;
  logic                 slice_ready;
  logic [AddrWidth-1:0] slice_src;
  logic [AddrWidth-1:0] slice_dst;
  logic [LenWidth-1:0]  slice_len;

  logic                 split_valid;
  logic                 split_ready;
  logic [AddrWidth-1:0] split_src;
  logic [AddrWidth-1:0] split_dst;
  logic [LenWidth-1:0]  split_len;

  logic                 issue;

  dma_req_slice i_req_slice (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .in_valid_i (req_valid_i),
    .in_ready_o (req_ready_o),
    .in_src_i   (req_src_i  ),
    .in_dst_i   (req_dst_i  ),
    .in_len_i   (req_len_i  ),
    .out_valid_o(slice_valid),
    .out_ready_i(slice_ready),
    .out_src_o  (slice_src  ),
    .out_dst_o  (slice_dst  ),
    .out_len_o  (slice_len  )
  );

  dma_region_splitter i_region_splitter (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .in_valid_i (slice_valid),
    .in_ready_o (slice_ready),
    .in_src_i   (slice_src  ),
    .in_dst_i   (slice_dst  ),
    .in_len_i   (slice_len  ),
    .out_valid_o(split_valid),
    .out_ready_i(split_ready),
    .out_src_o  (split_src  ),
    .out_dst_o  (split_dst  ),
    .out_len_o  (split_len  )
  );

  dma_group_distributor i_group_distributor (
    .clk_i        (clk_i        ),
    .rst_i        (rst_i        ),
    .in_valid_i   (split_valid  ),
    .in_ready_o   (split_ready  ),
    .in_src_i     (split_src    ),
    .in_dst_i     (split_dst    ),
    .in_len_i     (split_len    ),
    .group_valid_o(group_valid_o),
    .group_ready_i(group_ready_i),
    .group_src_o  (group_src_o  ),
    .group_dst_o  (group_dst_o  ),
    .group_len_o  (group_len_o  )
  );

  // A piece leaves when its group takes it
  assign issue = |(group_valid_o & group_ready_i);

  dma_status_tracker i_status_tracker (
    .clk_i        (clk_i         ),
    .rst_i        (rst_i         ),
    .slice_valid_i(slice_valid   ),
    .split_valid_i(split_valid   ),
    .dist_valid_i (|group_valid_o),
    .issue_i      (issue         ),
    .group_done_i (group_done_i  ),
    .dma_idle_o   (dma_idle_o    )
  );

  // Accepted request shows up as busy once it sits in the slice
  a_busy_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i && req_ready_o |-> ##2 !dma_idle_o);

endmodule

// File: logic/dma_status_tracker.sv
// ##########################################################
// DMA status tracker
// Counts outstanding pieces and flags an idle DMA
// ##########################################################

`timescale 1ns/1ps

module dma_status_tracker import dma_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 slice_valid_i,
  input  logic                 split_valid_i,
  input  logic                 dist_valid_i,
  input  logic                 issue_i,
  input  logic [NumGroups-1:0] group_done_i,
  output logic                 dma_idle_o
);

  logic [OutstandingWidth-1:0] cnt_q;
  logic [OutstandingWidth-1:0] done_cnt;
  logic                        pipe_busy;

  // Several groups may finish in the same cycle
  always_comb begin
    done_cnt = '0;
    for (int i = 0; i < NumGroups; i++) begin
      done_cnt = done_cnt + OutstandingWidth'(group_done_i[i]);
    end
  end

  assign pipe_busy = slice_valid_i || split_valid_i || dist_valid_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q      <= '0;
      dma_idle_o <= 1'b1;
    end else begin
      cnt_q      <= cnt_q + OutstandingWidth'(issue_i) - done_cnt;
      dma_idle_o <= !pipe_busy && (cnt_q == '0);
    end
  end

  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    ({1'b0, cnt_q} + (OutstandingWidth + 1)'(issue_i)) >= {1'b0, done_cnt});

endmodule

// File: logic/dma_group_distributor.sv
// ##########################################################
// DMA group distributor
// Cuts row pieces per group region and steers them to groups
// ##########################################################

`timescale 1ns/1ps

module dma_group_distributor import dma_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [AddrWidth-1:0] in_src_i,
  input  logic [AddrWidth-1:0] in_dst_i,
  input  logic [LenWidth-1:0]  in_len_i,
  output logic [NumGroups-1:0] group_valid_o,
  input  logic [NumGroups-1:0] group_ready_i,
  output logic [AddrWidth-1:0] group_src_o,
  output logic [AddrWidth-1:0] group_dst_o,
  output logic [LenWidth-1:0]  group_len_o
);

  logic [AddrWidth-1:0] rem_src_q;
  logic [AddrWidth-1:0] rem_dst_q;
  logic [LenWidth-1:0]  rem_len_q;

  logic                 rem_busy;
  logic                 taken;
  logic                 out_free;
  logic                 load_new;
  logic                 advance;
  logic [AddrWidth-1:0] cur_src;
  logic [AddrWidth-1:0] cur_dst;
  logic [LenWidth-1:0]  cur_len;
  logic [LenWidth-1:0]  room;
  logic [LenWidth-1:0]  piece_len;
  tcdm_addr_t           cur_addr;
  tcdm_addr_t           out_addr;

  // Only the addressed group sees valid, so its ready alone decides
  assign taken      = |(group_valid_o & group_ready_i);
  assign rem_busy   = rem_len_q != '0;
  assign out_free   = !(|group_valid_o) || taken;
  assign in_ready_o = !rem_busy && out_free;
  assign load_new   = in_valid_i && in_ready_o;
  assign advance    = rem_busy && out_free;

  always_comb begin
    if (rem_busy) begin
      cur_src = rem_src_q;
      cur_dst = rem_dst_q;
      cur_len = rem_len_q;
    end else begin
      cur_src = in_src_i;
      cur_dst = in_dst_i;
      cur_len = in_len_i;
    end
    cur_addr.addr = cur_dst;
    // Bytes left in the group region of the current destination
    room      = LenWidth'(GroupRegionBytes) - LenWidth'(cur_addr.field.offset);
    piece_len = (cur_len < room) ? cur_len : room;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      group_valid_o <= '0;
      rem_len_q     <= '0;
    end else if (load_new || advance) begin
      group_valid_o <= NumGroups'(1) << cur_addr.field.group_idx;
      rem_len_q     <= cur_len - piece_len;
    end else if (taken) begin
      group_valid_o <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_new || advance) begin
      group_src_o <= cur_src;
      group_dst_o <= cur_dst;
      group_len_o <= piece_len;
      rem_src_q   <= cur_src + AddrWidth'(piece_len);
      rem_dst_q   <= cur_dst + AddrWidth'(piece_len);
    end
  end

  assign out_addr.addr = group_dst_o;

  a_group_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(group_valid_o));

  // Piece stays inside the region of the group it is steered to
  a_within_group: assert property (@(posedge clk_i) disable iff (rst_i)
    |group_valid_o |-> group_valid_o[out_addr.field.group_idx] &&
    ({1'b0, group_len_o} + (LenWidth + 1)'(out_addr.field.offset))
    <= (LenWidth + 1)'(GroupRegionBytes));

endmodule

// File: logic/dma_region_splitter.sv
// ##########################################################
// DMA region splitter
// Cuts bursts at full interleaving row boundaries
// ##########################################################

`timescale 1ns/1ps

module dma_region_splitter import dma_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [AddrWidth-1:0] in_src_i,
  input  logic [AddrWidth-1:0] in_dst_i,
  input  logic [LenWidth-1:0]  in_len_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [AddrWidth-1:0] out_src_o,
  output logic [AddrWidth-1:0] out_dst_o,
  output logic [LenWidth-1:0]  out_len_o
);

  // Remainder of the burst still to be issued
  logic [AddrWidth-1:0] rem_src_q;
  logic [AddrWidth-1:0] rem_dst_q;
  logic [LenWidth-1:0]  rem_len_q;

  logic                 rem_busy;
  logic                 out_free;
  logic                 load_new;
  logic                 advance;
  logic [AddrWidth-1:0] cur_src;
  logic [AddrWidth-1:0] cur_dst;
  logic [LenWidth-1:0]  cur_len;
  logic [LenWidth-1:0]  room;
  logic [LenWidth-1:0]  piece_len;
  tcdm_addr_t           cur_addr;
  tcdm_addr_t           out_addr;

  assign rem_busy   = rem_len_q != '0;
  assign out_free   = !out_valid_o || out_ready_i;
  assign in_ready_o = !rem_busy && out_free;
  assign load_new   = in_valid_i && in_ready_o;
  assign advance    = rem_busy && out_free;

  always_comb begin
    if (rem_busy) begin
      cur_src = rem_src_q;
      cur_dst = rem_dst_q;
      cur_len = rem_len_q;
    end else begin
      cur_src = in_src_i;
      cur_dst = in_dst_i;
      cur_len = in_len_i;
    end
    cur_addr.addr = cur_dst;
    // Bytes left before the next row boundary
    room = LenWidth'(RowRegionBytes) -
           LenWidth'({cur_addr.field.group_idx, cur_addr.field.offset});
    piece_len = (cur_len < room) ? cur_len : room;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
      rem_len_q   <= '0;
    end else if (load_new || advance) begin
      out_valid_o <= 1'b1;
      rem_len_q   <= cur_len - piece_len;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_new || advance) begin
      out_src_o <= cur_src;
      out_dst_o <= cur_dst;
      out_len_o <= piece_len;
      rem_src_q <= cur_src + AddrWidth'(piece_len);
      rem_dst_q <= cur_dst + AddrWidth'(piece_len);
    end
  end

  assign out_addr.addr = out_dst_o;

  a_within_row: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o |-> ({1'b0, out_len_o} +
    (LenWidth + 1)'({out_addr.field.group_idx, out_addr.field.offset}))
    <= (LenWidth + 1)'(RowRegionBytes));

endmodule

// File: logic/dma_req_slice.sv
// ##########################################################
// DMA request slice
// Two-entry spill register with a registered input ready
// ##########################################################

`timescale 1ns/1ps

module dma_req_slice import dma_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [AddrWidth-1:0] in_src_i,
  input  logic [AddrWidth-1:0] in_dst_i,
  input  logic [LenWidth-1:0]  in_len_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [AddrWidth-1:0] out_src_o,
  output logic [AddrWidth-1:0] out_dst_o,
  output logic [LenWidth-1:0]  out_len_o
);

  logic                 a_full_q;
  logic                 b_full_q;
  logic [AddrWidth-1:0] b_src_q;
  logic [AddrWidth-1:0] b_dst_q;
  logic [LenWidth-1:0]  b_len_q;
  logic                 push;
  logic                 take_out;
  logic                 to_spill;

  assign in_ready_o  = !b_full_q;
  assign out_valid_o = a_full_q;
  assign push        = in_valid_i && in_ready_o;
  assign take_out    = a_full_q && out_ready_i;
  // Output busy and not drained, so park the new request in the spill entry
  assign to_spill    = a_full_q && !out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else if (b_full_q) begin
      if (take_out) begin
        b_full_q <= 1'b0;
      end
    end else if (push) begin
      if (to_spill) begin
        b_full_q <= 1'b1;
      end else begin
        a_full_q <= 1'b1;
      end
    end else if (take_out) begin
      a_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_full_q) begin
      if (take_out) begin
        out_src_o <= b_src_q;
        out_dst_o <= b_dst_q;
        out_len_o <= b_len_q;
      end
    end else if (push && to_spill) begin
      b_src_q <= in_src_i;
      b_dst_q <= in_dst_i;
      b_len_q <= in_len_i;
    end else if (push) begin
      out_src_o <= in_src_i;
      out_dst_o <= in_dst_i;
      out_len_o <= in_len_i;
    end
  end

  a_nonzero_len: assert property (@(posedge clk_i) disable iff (rst_i)
    in_valid_i |-> in_len_i != '0);

  a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_src_o) &&
    $stable(out_dst_o) && $stable(out_len_o));

endmodule

// File: logic/dma_pkg.sv
// ##########################################################
// DMA front end package
// Address and length widths, TCDM region sizes, address view
// ##########################################################

package dma_pkg;

  // Request field widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned LenWidth  = 16;

  // TCDM organisation
  localparam int unsigned NumGroups        = 4;
  localparam int unsigned NumBanksPerGroup = 16;
  localparam int unsigned BankBytes        = 4;

  // Bytes one group owns before the next group takes over
  localparam int unsigned GroupRegionBytes = NumBanksPerGroup * BankBytes;
  // One interleaving row across every group
  localparam int unsigned RowRegionBytes   = GroupRegionBytes * NumGroups;

  localparam int unsigned GroupIdxWidth    = $clog2(NumGroups);
  localparam int unsigned GroupOffsetWidth = $clog2(GroupRegionBytes);
  localparam int unsigned RowWidth         = AddrWidth - GroupIdxWidth - GroupOffsetWidth;

  // Pieces issued to groups and not yet completed
  localparam int unsigned OutstandingWidth = 8;

  // TCDM destination address, flat or split into its interleaving fields
  typedef union packed {
    logic [AddrWidth-1:0] addr;
    struct packed {
      logic [RowWidth-1:0]         row;
      logic [GroupIdxWidth-1:0]    group_idx;
      logic [GroupOffsetWidth-1:0] offset;
    } field;
  } tcdm_addr_t;

endpackage
